//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := dmaCpuPortTb
FILELIST  := src.f
OBJDIR    := obj_dir

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJDIR) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJDIR)

//--- src.f
verilog/dmaTypesPkg.sv
verilog/busTypesPkg.sv
verilog/cpuSmTerms.sv
verilog/cpuSmOutputs.sv
verilog/cpuSmRegs.sv
verilog/fifoWordCounter.sv
verilog/dmaCpuPort.sv
verif/dmaCpuPortTb.sv

//--- verif/dmaCpuPortTb.sv
// DMA CPU port testbench with a bus-slave model, FIFO count reference and bus protocol checks
`timescale 1ns/1ps
`default_nettype none

module dmaCpuPortTb
    import dmaTypesPkg::*;
    import busTypesPkg::*;
();

    localparam int fifoDepthTb = 8;
    localparam int countW = $clog2(fifoDepthTb + 1);
    // About 700 cycles for fill, drain, grant hold-off and four random blocks of 150
    localparam int cycleLimit = 4000;
    localparam logic [countW-1:0] fullCount = countW'(fifoDepthTb);

    logic              clk;
    logic              rstN;
    logic              dmaEnable;
    xferDir_e          dir;
    logic              bgrant;
    logic              sterm;
    logic              dsack;
    logic              cycleDone;
    logic              scsiPut;
    logic              scsiTake;
    busAck_t           ack;
    busCtrl_t          ctrl;
    logic [countW-1:0] fifoCount;

    int                errors = 0;
    int                seed = 32'hfc653a22;
    int                cycles = 0;
    int                latchPulses = 0;
    int                drainPulses = 0;
    logic              quietCheck = 1'b1;
    logic [countW-1:0] modelCount = '0;
    // cycleEnd expected one and two cycles ahead
    logic              endDue1 = 1'b0;
    logic              endDue2 = 1'b0;

    assign ack = '{dsack: dsack, sterm: sterm, bgrant: bgrant};

    dmaCpuPort #(
        .fifoDepth (fifoDepthTb)
    ) i_dmaCpuPort (
        .clk       (clk),
        .rstN      (rstN),
        .dmaEnable (dmaEnable),
        .dir       (dir),
        .ack       (ack),
        .cycleDone (cycleDone),
        .scsiPut   (scsiPut),
        .scsiTake  (scsiTake),
        .ctrl      (ctrl),
        .fifoCount (fifoCount)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic reportError(input string msg);
        errors++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    // Expected count after one clock with each source moving one word, clamped to the FIFO size
    function automatic logic [countW-1:0] refCount(input logic [countW-1:0] count,
            input logic inc, input logic dec, input logic put, input logic take);
        int net;
        net = int'(count) + int'(inc) + int'(put) - int'(dec) - int'(take);
        if (net < 0) begin
            net = 0;
        end else if (net > fifoDepthTb) begin
            net = fifoDepthTb;
        end
        return countW'(net);
    endfunction

    // Compare process samples everything mid-cycle
    always @(negedge clk) begin
        if (quietCheck && (ctrl !== '0 || fifoCount !== '0)) begin
            reportError($sformatf("outputs not quiet, ctrl=%b count=%0d", ctrl, fifoCount));
        end
        if (fifoCount !== modelCount) begin
            reportError($sformatf("fifoCount %0d, expected %0d", fifoCount, modelCount));
        end
        modelCount = rstN ? refCount(modelCount, ctrl.incFifo, ctrl.decFifo, scsiPut, scsiTake)
                          : '0;
        if ((ctrl.as || ctrl.ds) && !ctrl.bgack) begin
            reportError("as or ds high without bgack");
        end
        if (ctrl.ds && dir == dirFifoToCpu && !ctrl.dataDrive) begin
            reportError("ds high on a FIFO read without dataDrive");
        end
        if (ctrl.dataDrive && (dir == dirCpuToFifo || !ctrl.as)) begin
            reportError("dataDrive outside the strobe window of a FIFO read");
        end
        // One count strobe per completed bus cycle, picked by the direction
        if (ctrl.latchWord !== (ctrl.cycleEnd && dir == dirCpuToFifo) ||
                ctrl.incFifo !== (ctrl.cycleEnd && dir == dirCpuToFifo) ||
                ctrl.decFifo !== (ctrl.cycleEnd && dir == dirFifoToCpu)) begin
            reportError($sformatf("latchWord=%b incFifo=%b decFifo=%b with cycleEnd=%b",
                                  ctrl.latchWord, ctrl.incFifo, ctrl.decFifo, ctrl.cycleEnd));
        end
        if (ctrl.cycleEnd !== endDue1) begin
            reportError($sformatf("cycleEnd %b, expected %b", ctrl.cycleEnd, endDue1));
        end
        endDue1 = endDue2 | (ctrl.ds & sterm);
        endDue2 = ctrl.ds & dsack & ~sterm;
        if (ctrl.latchWord) begin
            latchPulses++;
        end
        if (ctrl.cycleEnd && ctrl.decFifo) begin
            drainPulses++;
        end
    end

    // Bus slave giving one random acknowledge per data strobe
    initial begin
        int   r;
        logic answered;
        answered = 1'b0;
        sterm <= 1'b0;
        dsack <= 1'b0;
        forever begin
            @(negedge clk);
            if (ctrl.ds && !answered) begin
                answered = 1'b1;
                r = $random(seed);
                repeat (r[1:0]) @(posedge clk);
                @(posedge clk);
                if (r[2]) begin
                    sterm <= 1'b1;
                end else begin
                    dsack <= 1'b1;
                end
                @(posedge clk);
                sterm <= 1'b0;
                dsack <= 1'b0;
            end else if (!ctrl.ds) begin
                answered = 1'b0;
            end
        end
    end

    initial begin
        while (cycles < cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: testbench still running after %0d clock cycles", cycleLimit);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic waitForCount(input logic [countW-1:0] target);
        do begin
            @(negedge clk);
        end while (fifoCount != target);
    endtask

    task automatic waitBusIdle();
        do begin
            @(negedge clk);
        end while (ctrl.breq || ctrl.bgack);
    endtask

    task automatic checkReleased(input int n, input logic [countW-1:0] expCount,
            input string what);
        repeat (n) begin
            @(negedge clk);
            if (ctrl.breq || ctrl.bgack || fifoCount != expCount) begin
                reportError($sformatf("%s: breq=%b bgack=%b count=%0d", what, ctrl.breq,
                                      ctrl.bgack, fifoCount));
            end
        end
    endtask

    task automatic checkHeldOff(input int n, input string what);
        repeat (n) begin
            @(negedge clk);
            if (!ctrl.breq || ctrl.bgack || ctrl.as || ctrl.ds) begin
                reportError($sformatf("%s: bus taken, ctrl=%b", what, ctrl));
            end
        end
    endtask

    initial begin
        int startLatch;
        int startDrain;
        int r;
        rstN <= 1'b0;
        dmaEnable <= 1'b0;
        dir <= dirCpuToFifo;
        bgrant <= 1'b0;
        cycleDone <= 1'b0;
        scsiPut <= 1'b0;
        scsiTake <= 1'b0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        // Reset cycles and the first cycle after reset
        repeat (2) @(negedge clk);

        // Fill the FIFO from the bus
        @(posedge clk);
        quietCheck = 1'b0;
        startLatch = latchPulses;
        bgrant <= 1'b1;
        cycleDone <= 1'b1;
        dmaEnable <= 1'b1;
        waitForCount(fullCount);
        checkReleased(8, fullCount, "FIFO full");
        if (latchPulses - startLatch != fifoDepthTb) begin
            reportError($sformatf("%0d latchWord pulses on fill", latchPulses - startLatch));
        end

        // Drain it onto the bus
        @(posedge clk);
        startDrain = drainPulses;
        dir <= dirFifoToCpu;
        waitForCount('0);
        checkReleased(8, '0, "FIFO empty");
        if (drainPulses - startDrain != fifoDepthTb) begin
            reportError($sformatf("%0d drain cycles from a full FIFO",
                                  drainPulses - startDrain));
        end

        // Grant and previous master hold-off
        @(posedge clk);
        dir <= dirCpuToFifo;
        bgrant <= 1'b0;
        do begin
            @(negedge clk);
        end while (!ctrl.breq);
        checkHeldOff(6, "no grant");
        @(posedge clk);
        bgrant <= 1'b1;
        cycleDone <= 1'b0;
        checkHeldOff(6, "previous master busy");
        @(posedge clk);
        cycleDone <= 1'b1;
        @(negedge clk);
        if (ctrl.bgack) begin
            reportError("bgack before grant was sampled");
        end
        @(negedge clk);
        if (!ctrl.bgack || ctrl.as) begin
            reportError($sformatf("ownership cycle: bgack=%b as=%b", ctrl.bgack, ctrl.as));
        end
        @(negedge clk);
        if (!ctrl.as) begin
            reportError("as not high one cycle after bgack");
        end
        @(posedge clk);
        dmaEnable <= 1'b0;
        waitBusIdle();

        // Random SCSI traffic and bus hold-off in both directions
        for (int blk = 0; blk < 4; blk++) begin
            @(posedge clk);
            dir <= (blk % 2 == 0) ? dirCpuToFifo : dirFifoToCpu;
            dmaEnable <= 1'b1;
            repeat (150) begin
                @(posedge clk);
                r = $random(seed);
                scsiPut <= (r[2:0] == 3'd0);
                scsiTake <= (r[5:3] == 3'd0);
                cycleDone <= (r[7:6] != 2'd0);
            end
            @(posedge clk);
            scsiPut <= 1'b0;
            scsiTake <= 1'b0;
            cycleDone <= 1'b1;
            dmaEnable <= 1'b0;
            waitBusIdle();
        end

        @(posedge clk);
        $display("Run complete: %0d errors in %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/busTypesPkg.sv
// Bus signal bundles: acknowledges, sequencer product terms and registered bus strobes
`default_nettype none

package busTypesPkg;

    // Bus inputs, all active high
    typedef struct packed {
        logic dsack;     // asynchronous acknowledge
        logic sterm;     // synchronous termination
        logic bgrant;
    } busAck_t;

    // One bit per product term, at most one set per state branch
    typedef struct packed {
        logic idleGo;
        logic reqWait;
        logic reqTake;
        logic own;
        logic addr;
        logic dataWait;
        logic dataSync;
        logic dataAsync;
        logic ackSync;
        logic latchMore;
        logic latchDone;
        logic releaseBus;
    } smTerms_t;

    // Registered bus and FIFO strobes
    typedef struct packed {
        logic breq;
        logic bgack;
        logic as;
        logic ds;
        // FIFO word drives the data bus
        logic dataDrive;
        // Bus word is written into the FIFO
        logic latchWord;
        logic incFifo;
        logic decFifo;
        // Single pulse per completed bus cycle
        logic cycleEnd;
    } busCtrl_t;

endpackage

`default_nettype wire

//--- verilog/cpuSmOutputs.sv
// CPU-side sequencer equations, next state and next strobe values as sums of product terms
`timescale 1ns/1ps
`default_nettype none

module cpuSmOutputs
    import dmaTypesPkg::*;
    import busTypesPkg::*;
(
    input  smTerms_t  terms,
    input  xferDir_e  dir,
    output cpuState_e nextState,
    output busCtrl_t  nextCtrl
);

    // Terms that lead into each state on the next clock
    logic toIdle;
    logic toRequest;
    logic toOwn;
    logic toAddress;
    logic toData;
    logic toAckSync;
    logic toLatch;
    logic toRelease;

    logic       fifoToCpu;
    logic [4:0] stateBits;

    // No term fires in sIdle without work or in an unused encoding,
    // both fall back to sIdle
    assign toIdle    = terms.releaseBus | ~(|terms);
    assign toRequest = terms.idleGo | terms.reqWait;
    assign toOwn     = terms.reqTake;
    assign toAddress = terms.own | terms.latchMore;
    assign toData    = terms.addr | terms.dataWait;
    assign toAckSync = terms.dataAsync;
    assign toLatch   = terms.dataSync | terms.ackSync;
    assign toRelease = terms.latchDone;

    assign fifoToCpu = (dir == dirFifoToCpu);

    // Next-state bits
    //   sIdle    00001   sRequest 00010   sOwn     01000   sAddress 01100
    //   sData    10100   sAckSync 10101   sLatch   11100   sRelease 10000
    assign stateBits[0] = toIdle | toAckSync;
    assign stateBits[1] = toRequest;
    assign stateBits[2] = toAddress | toData | toAckSync | toLatch;
    assign stateBits[3] = toOwn | toAddress | toLatch;
    assign stateBits[4] = toData | toAckSync | toLatch | toRelease;

    assign nextState = cpuState_e'(stateBits);

    // Each strobe is set for the states that own it, so the registered copy
    // lines up with the registered state
    always_comb begin
        nextCtrl.breq = toRequest;

        // Ownership held from sOwn through sLatch
        nextCtrl.bgack = toOwn | toAddress | toData | toAckSync | toLatch;

        nextCtrl.as = toAddress | toData | toAckSync;
        nextCtrl.ds = toData | toAckSync;

        // Read from the FIFO, data is on the bus for the whole strobe window
        nextCtrl.dataDrive = fifoToCpu & (toAddress | toData | toAckSync);

        // Count strobes fire once per word, in sLatch
        nextCtrl.latchWord = ~fifoToCpu & toLatch;
        nextCtrl.incFifo   = ~fifoToCpu & toLatch;
        nextCtrl.decFifo   = fifoToCpu & toLatch;

        nextCtrl.cycleEnd = toLatch;
    end

endmodule

`default_nettype wire

//--- verilog/cpuSmRegs.sv
// CPU-side sequencer registers, state flops and registered bus strobes
`timescale 1ns/1ps
`default_nettype none

module cpuSmRegs
    import dmaTypesPkg::*;
    import busTypesPkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    // From the equations block
    input  cpuState_e nextState,
    input  busCtrl_t  nextCtrl,
    // Current state back to the decoder
    output cpuState_e state,
    // Strobes to the bus and the FIFO counter
    output busCtrl_t  ctrl
);

    // State register, comes out of reset waiting for work
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= sIdle;
        end else begin
            state <= nextState;
        end
    end

    // Strobe flops
    // All strobes low in reset, the bus is neither requested nor held
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ctrl <= '0;
        end else begin
            ctrl <= nextCtrl;
        end
    end

endmodule

`default_nettype wire

//--- verilog/cpuSmTerms.sv
// CPU-side sequencer decoder, turns state, request conditions and acknowledges into product terms
`timescale 1ns/1ps
`default_nettype none

module cpuSmTerms
    import dmaTypesPkg::*;
    import busTypesPkg::*;
(
    input  cpuState_e state,
    input  logic      dmaEnable,
    input  xferDir_e  dir,
    input  busAck_t   ack,
    input  logic      cycleDone,
    input  logic      fifoEmpty,
    input  logic      fifoFull,
    output smTerms_t  terms
);

    // One-hot state decode
    logic stIdle;
    logic stRequest;
    logic stOwn;
    logic stAddress;
    logic stData;
    logic stAckSync;
    logic stLatch;
    logic stRelease;

    logic workAvail;
    logic busFree;

    assign stIdle    = (state == sIdle);
    assign stRequest = (state == sRequest);
    assign stOwn     = (state == sOwn);
    assign stAddress = (state == sAddress);
    assign stData    = (state == sData);
    assign stAckSync = (state == sAckSync);
    assign stLatch   = (state == sLatch);
    assign stRelease = (state == sRelease);

    // Room to write or a word to read, flags already reflect the word in flight
    assign workAvail = dmaEnable &
                       (((dir == dirCpuToFifo) & ~fifoFull) |
                        ((dir == dirFifoToCpu) & ~fifoEmpty));

    // Grant alone is not enough, the previous master must be off the bus
    assign busFree = ack.bgrant & cycleDone;

    assign terms.idleGo     = stIdle & workAvail;
    assign terms.reqWait    = stRequest & ~busFree;
    assign terms.reqTake    = stRequest & busFree;
    assign terms.own        = stOwn;
    assign terms.addr       = stAddress;
    assign terms.dataWait   = stData & ~ack.sterm & ~ack.dsack;
    // sterm wins over dsack when both arrive together
    assign terms.dataSync   = stData & ack.sterm;
    assign terms.dataAsync  = stData & ack.dsack & ~ack.sterm;
    assign terms.ackSync    = stAckSync;
    assign terms.latchMore  = stLatch & workAvail;
    assign terms.latchDone  = stLatch & ~workAvail;
    assign terms.releaseBus = stRelease;

endmodule

`default_nettype wire

//--- verilog/dmaCpuPort.sv
// DMA CPU-side port, bus sequencer chain plus FIFO word counter
`timescale 1ns/1ps
`default_nettype none

module dmaCpuPort
    import dmaTypesPkg::*;
    import busTypesPkg::*;
#(
    parameter int fifoDepth = 8
) (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             dmaEnable,
    input  xferDir_e                         dir,
    input  busAck_t                          ack,
    input  logic                             cycleDone,
    // SCSI side of the FIFO
    input  logic                             scsiPut,
    input  logic                             scsiTake,
    output busCtrl_t                         ctrl,
    output logic [$clog2(fifoDepth + 1)-1:0] fifoCount
);

    cpuState_e state;
    cpuState_e nextState;
    smTerms_t  terms;
    busCtrl_t  nextCtrl;
    logic      fifoEmpty;
    logic      fifoFull;

    cpuSmTerms i_cpuSmTerms (
        .state     (state),
        .dmaEnable (dmaEnable),
        .dir       (dir),
        .ack       (ack),
        .cycleDone (cycleDone),
        .fifoEmpty (fifoEmpty),
        .fifoFull  (fifoFull),
        .terms     (terms)
    );

    cpuSmOutputs i_cpuSmOutputs (
        .terms     (terms),
        .dir       (dir),
        .nextState (nextState),
        .nextCtrl  (nextCtrl)
    );

    cpuSmRegs i_cpuSmRegs (
        .clk       (clk),
        .rstN      (rstN),
        .nextState (nextState),
        .nextCtrl  (nextCtrl),
        .state     (state),
        .ctrl      (ctrl)
    );

    // Counter is fed by the registered count strobes
    fifoWordCounter #(
        .fifoDepth (fifoDepth)
    ) i_fifoWordCounter (
        .clk       (clk),
        .rstN      (rstN),
        .incFifo   (ctrl.incFifo),
        .decFifo   (ctrl.decFifo),
        .scsiPut   (scsiPut),
        .scsiTake  (scsiTake),
        .fifoCount (fifoCount),
        .fifoEmpty (fifoEmpty),
        .fifoFull  (fifoFull)
    );

endmodule

`default_nettype wire

//--- verilog/dmaTypesPkg.sv
// DMA sequencer types: CPU-side bus sequencer states and transfer direction
`default_nettype none

package dmaTypesPkg;

    // CPU-side sequencer states
    // Sparse 5-bit encoding, the next-state bits are built as sums of product terms.
    // Only sIdle has bit 0 set on its own, so a cycle where no term fires lands there
    typedef enum logic [4:0] {
        // Waiting for work
        sIdle    = 5'h01,
        // Bus requested, waiting for grant and the previous master
        sRequest = 5'h02,
        // Bus taken, bgack asserted
        sOwn     = 5'h08,
        // Address strobe phase
        sAddress = 5'h0C,
        // Data strobe phase, waiting for sterm or dsack
        sData    = 5'h14,
        // Extra state to synchronise an asynchronous dsack
        sAckSync = 5'h15,
        // Word latched or driven, FIFO count strobes pulse here
        sLatch   = 5'h1C,
        // Bus handed back
        sRelease = 5'h10
    } cpuState_e;

    // Transfer direction between the CPU bus and the word FIFO
    typedef enum logic {
        // Bus write, words go into the FIFO
        dirCpuToFifo = 1'b0,
        // Bus read, FIFO words are driven onto the bus
        dirFifoToCpu = 1'b1
    } xferDir_e;

endpackage

`default_nettype wire

//--- verilog/fifoWordCounter.sv
// FIFO word counter, net step from CPU-side and SCSI-side strobes with look-ahead flags
`timescale 1ns/1ps
`default_nettype none

module fifoWordCounter #(
    parameter int fifoDepth = 8
) (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             incFifo,
    input  logic                             decFifo,
    input  logic                             scsiPut,
    input  logic                             scsiTake,
    output logic [$clog2(fifoDepth + 1)-1:0] fifoCount,
    // Flags describe the count after this clock
    output logic                             fifoEmpty,
    output logic                             fifoFull
);

    localparam int countW = $clog2(fifoDepth + 1);

    logic [1:0]        puts;
    logic [1:0]        takes;
    logic [countW+1:0] raised;
    logic [countW+1:0] settled;
    logic [countW-1:0] nextCount;

    // Up to two words in and two out per clock
    assign puts  = {1'b0, incFifo} + {1'b0, scsiPut};
    assign takes = {1'b0, decFifo} + {1'b0, scsiTake};

    assign raised  = {2'b00, fifoCount} + {{countW{1'b0}}, puts};
    assign settled = raised - {{countW{1'b0}}, takes};

    // Saturate at both ends
    always_comb begin
        if (raised < {{countW{1'b0}}, takes}) begin
            nextCount = '0;
        end else if (settled > (countW + 2)'(fifoDepth)) begin
            nextCount = countW'(fifoDepth);
        end else begin
            nextCount = settled[countW-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            fifoCount <= '0;
        end else begin
            fifoCount <= nextCount;
        end
    end

    // Sequencer in sLatch sees the count with its own word already applied
    assign fifoEmpty = (nextCount == '0);
    assign fifoFull  = (nextCount == countW'(fifoDepth));

endmodule

`default_nettype wire
